// File: flist.f
core_pkg.sv
bus_pkg.sv
fetch_unit.sv
decode_stage.sv
register_file.sv
mem_arbiter.sv
exec_unit.sv
rv_core.sv
tb_clock_gen.sv
rv_core_props.sv
tb_rv_core.sv

// File: Makefile
TOP := tb_rv_core

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module $(TOP) -f flist.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;

    localparam bus_pkg::addr_t RESET_PC   = 32'h0000_0000;
    localparam int             NUM_REGS   = 16;
    localparam int             NUM_INSTS  = 400;
    localparam int             MAX_CYCLES = NUM_INSTS * 12 + 200;
    localparam int             INIT_INSTS = 15;

    logic              clock;
    logic              reset;
    bus_pkg::mem_req_t mem_req;
    bus_pkg::mem_rsp_t mem_rsp;
    bus_pkg::addr_t    pc;
    logic              retired;

    logic [31:0]     lfsr_state;
    core_pkg::word_t model_regs [16];
    core_pkg::word_t model_mem [64];
    bus_pkg::addr_t  model_pc;
    int              issued;
    int              retire_count;
    int              cycles;
    int              value_errors;
    int              protocol_errors;

    // data access that the last fetched instruction will make
    logic            expect_data;
    logic            expect_wen;
    bus_pkg::addr_t  expect_addr;
    core_pkg::word_t expect_wdata;
    core_pkg::word_t load_value;

    logic            pending;
    int              delay_left;
    core_pkg::word_t pending_rdata;
    logic            check_pc;

    tb_clock_gen clock_gen_i (
        .clock (clock),
        .reset (reset)
    );

    rv_core #(
        .RESET_PC (RESET_PC),
        .NUM_REGS (NUM_REGS)
    ) rv_core_i (
        .clock   (clock),
        .reset   (reset),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp),
        .pc      (pc),
        .retired (retired)
    );

    bind rv_core rv_core_props rv_core_props_i (
        .clock   (clock),
        .reset   (reset),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp),
        .retired (retired)
    );

    // the fibonacci lfsr uses taps 32, 22, 2 and 1 and steps once per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic core_pkg::word_t enc_r(logic [6:0] f7, logic [3:0] rs2,
                                              logic [3:0] rs1, logic [2:0] f3,
                                              logic [3:0] rd);
        return {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, 7'b0110011};
    endfunction

    function automatic core_pkg::word_t enc_i(logic [11:0] imm, logic [3:0] rs1,
                                              logic [2:0] f3, logic [3:0] rd,
                                              logic [6:0] opcode);
        return {imm, 1'b0, rs1, f3, 1'b0, rd, opcode};
    endfunction

    function automatic core_pkg::word_t enc_s(logic [11:0] imm, logic [3:0] rs2);
        return {imm[11:5], 1'b0, rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic core_pkg::word_t enc_b(logic [12:0] imm, logic [3:0] rs2,
                                              logic [3:0] rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], 1'b0, rs2, 1'b0, rs1, f3, imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic core_pkg::word_t enc_j(logic [20:0] imm, logic [3:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 1'b0, rd, 7'b1101111};
    endfunction

    function automatic void write_reg(logic [3:0] idx, core_pkg::word_t value);
        if (idx != 4'd0) begin
            model_regs[idx] = value;
        end
    endfunction

    // builds the next instruction and steps the reference model through it
    task automatic make_instruction(output core_pkg::word_t inst);
        int              sel;
        logic [3:0]      rd;
        logic [3:0]      rs1;
        logic [3:0]      rs2;
        logic [3:0]      offset;
        logic [11:0]     imm12;
        core_pkg::word_t imm;
        core_pkg::word_t a;
        core_pkg::word_t b;
        bus_pkg::addr_t  next;
        rd    = 4'(rand_bits(4));
        rs1   = 4'(rand_bits(4));
        rs2   = 4'(rand_bits(4));
        a     = model_regs[rs1];
        b     = model_regs[rs2];
        next  = model_pc + 32'd4;
        imm12 = 12'(rand_bits(12));
        imm   = {{20{imm12[11]}}, imm12};
        if (issued < INIT_INSTS) begin
            // give every register a known value before the mix starts
            rd   = 4'(issued + 1);
            inst = enc_i(imm12, 4'd0, 3'b000, rd, 7'b0010011);
            write_reg(rd, imm);
        end else begin
            sel = int'(rand_bits(4));
            case (sel)
                0: begin
                    inst = enc_r(7'h00, rs2, rs1, 3'b000, rd);
                    write_reg(rd, a + b);
                end
                1: begin
                    inst = enc_r(7'h20, rs2, rs1, 3'b000, rd);
                    write_reg(rd, a - b);
                end
                2: begin
                    inst = enc_r(7'h00, rs2, rs1, 3'b111, rd);
                    write_reg(rd, a & b);
                end
                3: begin
                    inst = enc_r(7'h00, rs2, rs1, 3'b110, rd);
                    write_reg(rd, a | b);
                end
                4: begin
                    inst = enc_r(7'h00, rs2, rs1, 3'b100, rd);
                    write_reg(rd, a ^ b);
                end
                5: begin
                    inst = enc_r(7'h00, rs2, rs1, 3'b010, rd);
                    write_reg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                end
                6, 7: begin
                    inst = enc_i(imm12, rs1, 3'b000, rd, 7'b0010011);
                    write_reg(rd, a + imm);
                end
                8: begin
                    imm  = {20'(rand_bits(20)), 12'h000};
                    inst = {imm[31:12], 1'b0, rd, 7'b0110111};
                    write_reg(rd, imm);
                end
                9, 10, 11, 12: begin
                    imm          = 32'h100 + {24'h0, 6'(rand_bits(6)), 2'b00};
                    expect_data  = 1'b1;
                    expect_addr  = imm;
                    expect_wen   = (sel >= 11);
                    expect_wdata = b;
                    if (sel >= 11) begin
                        inst                = enc_s(imm[11:0], rs2);
                        model_mem[imm[7:2]] = b;
                    end else begin
                        inst       = enc_i(imm[11:0], 4'd0, 3'b010, rd, 7'b0000011);
                        load_value = model_mem[imm[7:2]];
                        write_reg(rd, load_value);
                    end
                end
                13, 14: begin
                    offset = 4'(rand_bits(4));
                    imm    = {{26{offset[3]}}, offset, 2'b00};
                    inst   = enc_b(imm[12:0], rs2, rs1, (sel == 13) ? 3'b000 : 3'b001);
                    if ((sel == 13) == (a == b)) begin
                        next = model_pc + imm;
                    end
                end
                default: begin
                    offset = 4'(rand_bits(4));
                    imm    = {{26{offset[3]}}, offset, 2'b00};
                    inst   = enc_j(imm[20:0], rd);
                    write_reg(rd, model_pc + 32'd4);
                    next = model_pc + imm;
                end
            endcase
        end
        model_pc = next;
        issued++;
    endtask

    task automatic accept_request();
        core_pkg::word_t inst;
        delay_left = int'(rand_bits(2)) + 1;
        pending    = 1'b1;
        if (expect_data) begin
            assert (mem_req.wen == expect_wen) else begin
                $display("FAILED mem_req.wen: got %h expected %h", mem_req.wen, expect_wen);
                value_errors++;
            end
            assert (mem_req.addr == expect_addr) else begin
                $display("FAILED mem_req.addr: got %h expected %h", mem_req.addr, expect_addr);
                value_errors++;
            end
            if (expect_wen) begin
                assert (mem_req.wdata == expect_wdata) else begin
                    $display("FAILED mem_req.wdata: got %h expected %h",
                             mem_req.wdata, expect_wdata);
                    value_errors++;
                end
            end
            pending_rdata = expect_wen ? 32'h0 : load_value;
            expect_data   = 1'b0;
        end else begin
            assert (mem_req.wen == 1'b0) else begin
                $display("FAILED mem_req.wen: got %h expected %h on a fetch", mem_req.wen, 1'b0);
                value_errors++;
            end
            assert (mem_req.addr == model_pc) else begin
                $display("FAILED mem_req.addr: got %h expected %h", mem_req.addr, model_pc);
                value_errors++;
            end
            make_instruction(inst);
            pending_rdata = inst;
        end
    endtask

    // one falling edge of the memory model and the retire checks
    task automatic serve_cycle();
        logic busy_before;
        busy_before = pending;
        if (check_pc) begin
            assert (pc == model_pc) else begin
                $display("FAILED pc: got %h expected %h", pc, model_pc);
                value_errors++;
            end
            check_pc = 1'b0;
        end
        if (retired) begin
            retire_count++;
            check_pc = 1'b1;
        end
        mem_rsp.ok = 1'b0;
        if (pending) begin
            if (delay_left <= 1) begin
                mem_rsp.ok    = 1'b1;
                mem_rsp.rdata = pending_rdata;
                pending       = 1'b0;
            end else begin
                delay_left--;
            end
        end
        if (mem_req.req) begin
            assert (!busy_before) else begin
                $display("memory request arrived while the previous access was still open");
                protocol_errors++;
            end
            accept_request();
        end
    endtask

    initial begin
        bus_pkg::addr_t addr;
        mem_rsp         = '0;
        lfsr_state      = 32'h432fd2e9;
        model_pc        = RESET_PC;
        issued          = 0;
        retire_count    = 0;
        cycles          = 0;
        value_errors    = 0;
        protocol_errors = 0;
        expect_data     = 1'b0;
        expect_wen      = 1'b0;
        expect_addr     = '0;
        expect_wdata    = '0;
        load_value      = '0;
        pending         = 1'b0;
        delay_left      = 0;
        pending_rdata   = '0;
        check_pc        = 1'b0;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            addr         = 32'h100 + 32'(i) * 32'd4;
            model_mem[i] = (addr * 32'h9e3779b1) ^ 32'h5aa5_0f0f;
        end

        while (retire_count < NUM_INSTS && cycles < MAX_CYCLES) begin
            @(negedge clock);
            cycles++;
            if (reset) begin
                assert (!retired) else begin
                    $display("retired pulsed while reset was held");
                    protocol_errors++;
                end
            end else begin
                serve_cycle();
            end
        end

        if (retire_count < NUM_INSTS) begin
            $display("timeout: only %0d of %0d instructions retired in %0d cycles",
                     retire_count, NUM_INSTS, cycles);
            protocol_errors++;
        end
        $display("errors: %0d value, %0d protocol, %0d instructions retired",
                 value_errors, protocol_errors, retire_count);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: rv_core_props.sv
`timescale 1ns/100ps

module rv_core_props (
    input logic              clock,
    input logic              reset,
    input bus_pkg::mem_req_t mem_req,
    input bus_pkg::mem_rsp_t mem_rsp,
    input logic              retired
);

    logic outstanding;

    always_ff @(posedge clock) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (mem_req.req) begin
            outstanding <= 1'b1;
        end else if (mem_rsp.ok) begin
            outstanding <= 1'b0;
        end
    end

    no_overlap: assert property (@(posedge clock) disable iff (reset)
        outstanding |-> !mem_req.req)
        else $error("memory request issued while an access is outstanding");

    single_pulse: assert property (@(posedge clock) disable iff (reset)
        mem_req.req |=> !mem_req.req)
        else $error("memory request held for more than one cycle");

    // the first edge is skipped, state is only known once reset has been sampled
    quiet_reset: assert property (@(posedge clock)
        reset && $past(reset) |-> !retired)
        else $error("retired pulsed while reset was held");

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // reset is released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

// File: rv_core.sv
`timescale 1ns/100ps

module rv_core #(
    parameter bus_pkg::addr_t RESET_PC = '0,
    parameter int             NUM_REGS = 16
) (
    input  logic              clock,
    input  logic              reset,
    output bus_pkg::mem_req_t mem_req,
    input  bus_pkg::mem_rsp_t mem_rsp,
    output bus_pkg::addr_t    pc,
    output logic              retired
);

    bus_pkg::mem_req_t  fetch_req;
    bus_pkg::mem_rsp_t  fetch_rsp;
    bus_pkg::mem_req_t  data_req;
    bus_pkg::mem_rsp_t  data_rsp;
    logic               next_pc_valid;
    bus_pkg::addr_t     next_pc;
    logic               inst_valid;
    core_pkg::word_t    inst;
    logic               dec_valid;
    logic               dec_taken;
    core_pkg::decoded_t dec;
    core_pkg::word_t    rdata1;
    core_pkg::word_t    rdata2;
    logic               wen;
    core_pkg::reg_idx_t waddr;
    core_pkg::word_t    wdata;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_unit_i (
        .clock         (clock),
        .reset         (reset),
        .next_pc_valid (next_pc_valid),
        .next_pc       (next_pc),
        .fetch_req     (fetch_req),
        .fetch_rsp     (fetch_rsp),
        .inst_valid    (inst_valid),
        .inst          (inst)
    );

    decode_stage decode_stage_i (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec_taken  (dec_taken),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    // read ports follow the buffered instruction directly
    register_file #(
        .NUM_REGS (NUM_REGS)
    ) register_file_i (
        .clock  (clock),
        .wen    (wen),
        .waddr  (waddr),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    mem_arbiter mem_arbiter_i (
        .clock     (clock),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    exec_unit #(
        .RESET_PC (RESET_PC)
    ) exec_unit_i (
        .clock         (clock),
        .reset         (reset),
        .dec_valid     (dec_valid),
        .dec           (dec),
        .dec_taken     (dec_taken),
        .rdata1        (rdata1),
        .rdata2        (rdata2),
        .wen           (wen),
        .waddr         (waddr),
        .wdata         (wdata),
        .data_req      (data_req),
        .data_rsp      (data_rsp),
        .next_pc_valid (next_pc_valid),
        .next_pc       (next_pc),
        .pc            (pc),
        .retired       (retired)
    );

endmodule

// File: exec_unit.sv
`timescale 1ns/100ps

module exec_unit #(
    parameter bus_pkg::addr_t RESET_PC = '0
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               dec_valid,
    input  core_pkg::decoded_t dec,
    output logic               dec_taken,
    input  core_pkg::word_t    rdata1,
    input  core_pkg::word_t    rdata2,
    output logic               wen,
    output core_pkg::reg_idx_t waddr,
    output core_pkg::word_t    wdata,
    output bus_pkg::mem_req_t  data_req,
    input  bus_pkg::mem_rsp_t  data_rsp,
    output logic               next_pc_valid,
    output bus_pkg::addr_t     next_pc,
    output bus_pkg::addr_t     pc,
    output logic               retired
);

    typedef enum logic [1:0] {
        ex_idle,
        ex_execute,
        ex_memory,
        ex_done
    } exec_state_t;

    exec_state_t     state;
    logic            is_mem;
    logic            branch_taken;
    core_pkg::word_t alu_b;
    core_pkg::word_t alu_result;
    core_pkg::word_t load_data;
    bus_pkg::addr_t  pc_plus4;
    bus_pkg::addr_t  pc_target;

    // dec stays stable in the decode buffer until the next fetch completes
    assign is_mem    = (dec.kind == core_pkg::kind_load) || (dec.kind == core_pkg::kind_store);
    assign dec_taken = (state == ex_idle) && dec_valid;

    assign alu_b = dec.use_imm ? dec.imm : rdata2;

    always_comb begin
        case (dec.alu_op)
            core_pkg::alu_add:    alu_result = rdata1 + alu_b;
            core_pkg::alu_sub:    alu_result = rdata1 - alu_b;
            core_pkg::alu_and:    alu_result = rdata1 & alu_b;
            core_pkg::alu_or:     alu_result = rdata1 | alu_b;
            core_pkg::alu_xor:    alu_result = rdata1 ^ alu_b;
            core_pkg::alu_slt:    alu_result = {31'b0, $signed(rdata1) < $signed(alu_b)};
            core_pkg::alu_pass_b: alu_result = alu_b;
            default:              alu_result = rdata1 + alu_b;
        endcase
    end

    always_comb begin
        case (dec.kind)
            core_pkg::kind_branch_eq: branch_taken = (rdata1 == rdata2);
            core_pkg::kind_branch_ne: branch_taken = (rdata1 != rdata2);
            core_pkg::kind_jal:       branch_taken = 1'b1;
            default:                  branch_taken = 1'b0;
        endcase
    end

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + dec.imm;
    assign next_pc   = branch_taken ? pc_target : pc_plus4;

    // memory instructions finish in done, everything else in execute
    assign next_pc_valid = (state == ex_execute && !is_mem) || (state == ex_done);
    assign retired       = next_pc_valid;

    assign wen   = dec.writes_rd && next_pc_valid;
    assign waddr = dec.rd;
    assign wdata = (state == ex_done) ? load_data :
                   (dec.kind == core_pkg::kind_jal) ? pc_plus4 : alu_result;

    always_comb begin
        data_req.req   = (state == ex_execute) && is_mem;
        data_req.wen   = (dec.kind == core_pkg::kind_store);
        data_req.addr  = rdata1 + dec.imm;
        data_req.wdata = rdata2;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ex_idle;
            pc    <= RESET_PC;
        end else begin
            if (next_pc_valid) begin
                pc <= next_pc;
            end
            case (state)
                ex_idle:    if (dec_valid) state <= ex_execute;
                ex_execute: state <= is_mem ? ex_memory : ex_idle;
                ex_memory:  if (data_rsp.ok) state <= ex_done;
                ex_done:    state <= ex_idle;
                default:    state <= ex_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == ex_memory && data_rsp.ok) begin
            load_data <= data_rsp.rdata;
        end
    end

endmodule

// File: mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
    input  logic              clock,
    input  logic              reset,
    input  bus_pkg::mem_req_t fetch_req,
    output bus_pkg::mem_rsp_t fetch_rsp,
    input  bus_pkg::mem_req_t data_req,
    output bus_pkg::mem_rsp_t data_rsp,
    output bus_pkg::mem_req_t mem_req,
    input  bus_pkg::mem_rsp_t mem_rsp
);

    logic busy;
    logic owner_data;

    // execute has priority when both strobe together
    always_comb begin
        if (data_req.req) begin
            mem_req = data_req;
        end else begin
            mem_req = fetch_req;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy       <= 1'b0;
            owner_data <= 1'b0;
        end else if (mem_req.req) begin
            busy       <= 1'b1;
            owner_data <= data_req.req;
        end else if (mem_rsp.ok) begin
            busy <= 1'b0;
        end
    end

    always_comb begin
        fetch_rsp.ok    = mem_rsp.ok && busy && !owner_data;
        fetch_rsp.rdata = mem_rsp.rdata;
        data_rsp.ok     = mem_rsp.ok && busy && owner_data;
        data_rsp.rdata  = mem_rsp.rdata;
    end

endmodule

// File: register_file.sv
`timescale 1ns/100ps

module register_file #(
    parameter int NUM_REGS = 16
) (
    input  logic               clock,
    input  logic               wen,
    input  core_pkg::reg_idx_t waddr,
    input  core_pkg::reg_idx_t raddr1,
    input  core_pkg::reg_idx_t raddr2,
    input  core_pkg::word_t    wdata,
    output core_pkg::word_t    rdata1,
    output core_pkg::word_t    rdata2
);

    localparam int IDX_W = $clog2(NUM_REGS);

    core_pkg::word_t  regs [NUM_REGS];
    logic [IDX_W-1:0] widx;
    logic [IDX_W-1:0] ridx1;
    logic [IDX_W-1:0] ridx2;

    // with 16 registers the top index bit is simply not decoded
    assign widx  = waddr[IDX_W-1:0];
    assign ridx1 = raddr1[IDX_W-1:0];
    assign ridx2 = raddr2[IDX_W-1:0];

    always_ff @(posedge clock) begin
        if (wen && widx != '0) begin
            regs[widx] <= wdata;
        end
    end

    assign rdata1 = (ridx1 == '0) ? '0 : regs[ridx1];
    assign rdata2 = (ridx2 == '0) ? '0 : regs[ridx2];

endmodule

// File: decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic               clock,
    input  logic               reset,
    input  logic               inst_valid,
    input  core_pkg::word_t    inst,
    input  logic               dec_taken,
    output logic               dec_valid,
    output core_pkg::decoded_t dec
);

    core_pkg::opcode_t             opcode;
    logic [core_pkg::FUNCT3_W-1:0] funct3;
    logic [core_pkg::FUNCT7_W-1:0] funct7;
    core_pkg::word_t               imm_i;
    core_pkg::word_t               imm_s;
    core_pkg::word_t               imm_b;
    core_pkg::word_t               imm_j;
    core_pkg::word_t               imm_u;
    core_pkg::decoded_t            dec_next;

    assign opcode = core_pkg::opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        dec_next.kind      = core_pkg::kind_nop;
        dec_next.alu_op    = core_pkg::alu_add;
        dec_next.rs1       = inst[19:15];
        dec_next.rs2       = inst[24:20];
        dec_next.rd        = inst[11:7];
        dec_next.imm       = imm_i;
        dec_next.use_imm   = 1'b0;
        dec_next.writes_rd = 1'b0;
        case (opcode)
            core_pkg::op_reg: begin
                dec_next.kind      = core_pkg::kind_alu;
                dec_next.writes_rd = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec_next.alu_op = core_pkg::alu_add;
                    {7'b0100000, 3'b000}: dec_next.alu_op = core_pkg::alu_sub;
                    {7'b0000000, 3'b111}: dec_next.alu_op = core_pkg::alu_and;
                    {7'b0000000, 3'b110}: dec_next.alu_op = core_pkg::alu_or;
                    {7'b0000000, 3'b100}: dec_next.alu_op = core_pkg::alu_xor;
                    {7'b0000000, 3'b010}: dec_next.alu_op = core_pkg::alu_slt;
                    default: begin
                        dec_next.kind      = core_pkg::kind_nop;
                        dec_next.writes_rd = 1'b0;
                    end
                endcase
            end
            core_pkg::op_imm: begin
                // addi is the only immediate ALU form in the subset
                if (funct3 == 3'b000) begin
                    dec_next.kind      = core_pkg::kind_alu;
                    dec_next.use_imm   = 1'b1;
                    dec_next.writes_rd = 1'b1;
                end
            end
            core_pkg::op_lui: begin
                dec_next.kind      = core_pkg::kind_alu;
                dec_next.alu_op    = core_pkg::alu_pass_b;
                dec_next.imm       = imm_u;
                dec_next.use_imm   = 1'b1;
                dec_next.writes_rd = 1'b1;
            end
            core_pkg::op_load: begin
                if (funct3 == 3'b010) begin
                    dec_next.kind      = core_pkg::kind_load;
                    dec_next.writes_rd = 1'b1;
                end
            end
            core_pkg::op_store: begin
                dec_next.imm = imm_s;
                if (funct3 == 3'b010) begin
                    dec_next.kind = core_pkg::kind_store;
                end
            end
            core_pkg::op_branch: begin
                dec_next.imm = imm_b;
                if (funct3 == 3'b000) begin
                    dec_next.kind = core_pkg::kind_branch_eq;
                end else if (funct3 == 3'b001) begin
                    dec_next.kind = core_pkg::kind_branch_ne;
                end
            end
            core_pkg::op_jal: begin
                dec_next.kind      = core_pkg::kind_jal;
                dec_next.imm       = imm_j;
                dec_next.writes_rd = 1'b1;
            end
            default: dec_next.kind = core_pkg::kind_nop;
        endcase
    end

    // the one-entry buffer stays full from inst_valid until execute takes it
    always_ff @(posedge clock) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (inst_valid) begin
            dec_valid <= 1'b1;
        end else if (dec_taken) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (inst_valid) begin
            dec <= dec_next;
        end
    end

endmodule

// File: fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit #(
    parameter bus_pkg::addr_t RESET_PC = '0
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              next_pc_valid,
    input  bus_pkg::addr_t    next_pc,
    output bus_pkg::mem_req_t fetch_req,
    input  bus_pkg::mem_rsp_t fetch_rsp,
    output logic              inst_valid,
    output core_pkg::word_t   inst
);

    typedef enum logic [1:0] {
        fs_idle,
        fs_request,
        fs_wait
    } fetch_state_t;

    fetch_state_t   state;
    logic           boot;
    bus_pkg::addr_t fetch_pc;

    // the first fetch after reset starts without a next_pc_valid from execute
    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= fs_idle;
            boot       <= 1'b1;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            case (state)
                fs_idle: begin
                    if (boot || next_pc_valid) begin
                        state <= fs_request;
                        boot  <= 1'b0;
                    end
                end
                fs_request: state <= fs_wait;
                fs_wait: begin
                    if (fetch_rsp.ok) begin
                        state      <= fs_idle;
                        inst_valid <= 1'b1;
                    end
                end
                default: state <= fs_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_pc <= RESET_PC;
        end else if (next_pc_valid) begin
            fetch_pc <= next_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (state == fs_wait && fetch_rsp.ok) begin
            inst <= fetch_rsp.rdata;
        end
    end

    always_comb begin
        fetch_req.req   = (state == fs_request);
        fetch_req.wen   = 1'b0;
        fetch_req.addr  = fetch_pc;
        fetch_req.wdata = '0;
    end

endmodule

// File: bus_pkg.sv
package bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] bus_data_t;

    // req is a one-cycle strobe, the other fields are sampled with it
    typedef struct packed {
        logic      req;
        logic      wen;
        addr_t     addr;
        bus_data_t wdata;
    } mem_req_t;

    // ok pulses once per request, rdata is valid in that cycle on a read
    typedef struct packed {
        logic      ok;
        bus_data_t rdata;
    } mem_rsp_t;

endpackage

// File: core_pkg.sv
package core_pkg;

    localparam int XLEN = 32;
    localparam int REG_IDX_W = 5;
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // only the major opcodes of the supported subset
    typedef enum logic [OPCODE_W-1:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [2:0] {
        kind_alu,
        kind_load,
        kind_store,
        kind_branch_eq,
        kind_branch_ne,
        kind_jal,
        kind_nop
    } inst_kind_t;

    typedef struct packed {
        inst_kind_t kind;
        alu_op_t    alu_op;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        word_t      imm;
        logic       use_imm;
        logic       writes_rd;
    } decoded_t;

endpackage
